//--- include/decoder_config.svh
// ####################
// width and lane-count macros for
// the Fx instruction decoder
// ####################

`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

// instruction word and decoded field widths
`define ISTR_WIDTH 32
`define REG_ID_WIDTH 6
`define IMM_WIDTH 33
`define CMD_WIDTH 6

// N, M and O register fields
`define REG_LANES 3

`endif

//--- src/decodeTypesPkg.sv
// ####################
// vector typedefs for decoder fields
// operand form and immediate type enums
// ####################

package decodeTypesPkg;

`include "decoder_config.svh"

	typedef logic [`ISTR_WIDTH-1:0] istrWordT;
	typedef logic [`REG_ID_WIDTH-1:0] regIdT;

	// 4-bit field with its extension bit on top
	typedef logic [4:0] regFieldT;

	typedef logic [`IMM_WIDTH-1:0] immT;
	typedef logic [`CMD_WIDTH-1:0] uCmdT;
	typedef logic [`CMD_WIDTH-1:0] uIxtT;

	// operand layout that picks register routing and immediate build
	typedef enum logic [2:0] {
		formZ,
		formRegReg,
		formRegImmReg,
		formLdRegDispReg,
		formImm8Reg,
		formImm12Z,
		formImm12N,
		formInv
	} formModeT;

	// zero, ones or sign extension of the immediate
	typedef enum logic [1:0] {
		ityUW,
		ityNW,
		itySW,
		ityUB
	} immTypeT;

endpackage

//--- src/decodeOpsPkg.sv
// ####################
// command and index numbering
// access sizes, special register ids
// ####################

package decodeOpsPkg;

`include "decoder_config.svh"

	// major commands
	localparam logic [`CMD_WIDTH-1:0] cmdNop = 6'h00;
	localparam logic [`CMD_WIDTH-1:0] cmdMovRm = 6'h01;
	localparam logic [`CMD_WIDTH-1:0] cmdMovMr = 6'h02;
	localparam logic [`CMD_WIDTH-1:0] cmdLeaMr = 6'h03;
	localparam logic [`CMD_WIDTH-1:0] cmdAlu3 = 6'h04;
	localparam logic [`CMD_WIDTH-1:0] cmdMovIr = 6'h05;
	localparam logic [`CMD_WIDTH-1:0] cmdInvOp = 6'h3F;

	// alu and immediate-load indices
	localparam logic [`CMD_WIDTH-1:0] ixAdd = 6'h00;
	localparam logic [`CMD_WIDTH-1:0] ixSub = 6'h01;
	localparam logic [`CMD_WIDTH-1:0] ixAnd = 6'h05;
	localparam logic [`CMD_WIDTH-1:0] ixOr = 6'h06;
	localparam logic [`CMD_WIDTH-1:0] ixXor = 6'h07;
	localparam logic [`CMD_WIDTH-1:0] ixLdix = 6'h08;
	localparam logic [`CMD_WIDTH-1:0] ixLdish16 = 6'h09;

	// access sizes with bit 2 marking unsigned
	localparam int btyWidth = 3;
	localparam logic [btyWidth-1:0] btySB = 3'd0;
	localparam logic [btyWidth-1:0] btySW = 3'd1;
	localparam logic [btyWidth-1:0] btySL = 3'd2;
	localparam logic [btyWidth-1:0] btySQ = 3'd3;
	localparam logic [btyWidth-1:0] btyUB = 3'd4;
	localparam logic [btyWidth-1:0] btyUW = 3'd5;
	localparam logic [btyWidth-1:0] btyUL = 3'd6;

	// register ids
	localparam logic [`REG_ID_WIDTH-1:0] regR0 = 6'h00;
	localparam logic [`REG_ID_WIDTH-1:0] regR1 = 6'h01;
	localparam logic [`REG_ID_WIDTH-1:0] regPc = 6'h20;
	localparam logic [`REG_ID_WIDTH-1:0] regGbr = 6'h21;
	localparam logic [`REG_ID_WIDTH-1:0] regDlr = 6'h22;
	localparam logic [`REG_ID_WIDTH-1:0] regImm = 6'h3E;
	localparam logic [`REG_ID_WIDTH-1:0] regZzr = 6'h3F;

endpackage

//--- src/opcodeClassifier.sv
// ####################
// opcode classifier for Fx words
// form, immediate type, command, index, size
// raw register fields per lane
// ####################

`timescale 1ns/1ps

`include "decoder_config.svh"

module opcodeClassifier
	import decodeTypesPkg::*, decodeOpsPkg::*;
(
	input istrWordT istrWord,
	output formModeT form,
	output immTypeT ity,
	output uCmdT uCmd,
	output uIxtT uCmdIx,
	output logic [btyWidth-1:0] bty,
	output regFieldT laneField [`REG_LANES]
);

	logic exQ;
	logic isNotFx;

	assign exQ = istrWord[27];
	assign isNotFx = (istrWord[15:13] != 3'b111);

	always_comb begin
		form = formInv;
		ity = ityUB;
		uCmd = cmdInvOp;
		uCmdIx = '0;
		bty = btySB;

		casez (istrWord[11:8])
			// F0 three-register alu
			4'b0z00: begin
				casez (istrWord[31:16])
					16'h1zz0: uCmdIx = ixAdd;
					16'h1zz1: uCmdIx = ixSub;
					16'h1zz5: uCmdIx = ixAnd;
					16'h1zz6: uCmdIx = ixOr;
					16'h1zz7: uCmdIx = ixXor;
					default: uCmdIx = '0;
				endcase
				if (istrWord[31:28] == 4'h1 && istrWord[19:16] inside {4'h0, 4'h1,
						4'h5, 4'h6, 4'h7}) begin
					form = formRegReg;
					uCmd = cmdAlu3;
				end
			end

			// F1 load/store with displacement
			4'b0z01: begin
				case (istrWord[31:28])
					4'h0, 4'h1, 4'h2, 4'h3: begin
						uCmd = exQ ? cmdLeaMr : cmdMovRm;
						form = formLdRegDispReg;
						bty = {1'b0, istrWord[29:28]};
					end
					4'h8: begin
						uCmd = cmdMovMr;
						form = formLdRegDispReg;
						bty = exQ ? btyUB : btySB;
					end
					4'h9: begin
						uCmd = cmdMovMr;
						form = formLdRegDispReg;
						bty = exQ ? btyUW : btySW;
					end
					4'hA: begin
						uCmd = cmdMovMr;
						form = formLdRegDispReg;
						bty = exQ ? btyUL : btySL;
					end
					4'hB: begin
						uCmd = cmdMovMr;
						form = formLdRegDispReg;
						bty = exQ ? btyUL : btySQ;
					end
					default: begin
					end
				endcase
			end

			// F2 alu with 9-bit immediate
			4'b0z10: begin
				form = formRegImmReg;
				uCmd = cmdAlu3;
				ity = ityUW;
				case (istrWord[31:28])
					4'h0: uCmdIx = ixAdd;
					4'h1: begin
						uCmdIx = ixAdd;
						ity = ityNW;
					end
					4'h5: uCmdIx = ixAnd;
					4'h6: uCmdIx = ixOr;
					4'h7: uCmdIx = ixXor;
					default: begin
						form = formInv;
						uCmd = cmdInvOp;
						ity = ityUB;
					end
				endcase
			end

			// F8 16-bit immediate forms
			4'b100z: begin
				form = formImm8Reg;
				case (istrWord[7:5])
					3'b000: begin
						uCmd = cmdMovIr;
						ity = ityUW;
						uCmdIx = ixLdix;
					end
					3'b001: begin
						uCmd = cmdMovIr;
						ity = ityNW;
						uCmdIx = ixLdix;
					end
					3'b010: begin
						uCmd = cmdAlu3;
						ity = itySW;
						uCmdIx = ixAdd;
					end
					3'b011: begin
						uCmd = cmdMovIr;
						ity = ityUW;
						uCmdIx = ixLdish16;
					end
					default: form = formInv;
				endcase
			end

			4'hA: begin
				form = formImm12Z;
				uCmd = cmdMovIr;
				uCmdIx = ixLdix;
			end
			4'hB: begin
				form = formImm12N;
				uCmd = cmdMovIr;
				uCmdIx = ixLdix;
			end

			default: begin
			end
		endcase

		if (isNotFx || form == formInv) begin
			form = formInv;
			uCmd = cmdInvOp;
			uCmdIx = '0;
			bty = btySB;
		end
	end

	// F8 forms take the M-lane extension from bit 4
	always_comb begin
		laneField[0] = {istrWord[26], istrWord[7:4]};
		laneField[1] = {(form == formImm8Reg) ? istrWord[4] : istrWord[25], istrWord[3:0]};
		laneField[2] = {istrWord[24], istrWord[23:20]};
	end

endmodule

//--- src/regFieldResolver.sv
// ####################
// register field resolver
// maps field plus extension to a register id
// ####################

`timescale 1ns/1ps

module regFieldResolver
	import decodeTypesPkg::*, decodeOpsPkg::*;
(
	input regFieldT field,
	output regIdT regId,
	output logic isR0,
	output logic isR1
);

	logic inSpecialRange;

	// fields 0, 1 and 15 land in the special bank
	// unless the extension bit selects the upper half
	assign inSpecialRange = (field[3:1] == 3'b000) || (field[3:0] == 4'b1111);

	assign regId = {inSpecialRange & ~field[4], field[4], field[3:0]};

	// base checks ignore the special-bank bit
	assign isR0 = (regId[4:0] == regR0[4:0]);
	assign isR1 = (regId[4:0] == regR1[4:0]);

endmodule

//--- src/operandRouter.sv
// ####################
// operand router and output register
// per-form register routing and immediate build
// ####################

`timescale 1ns/1ps

`include "decoder_config.svh"

module operandRouter
	import decodeTypesPkg::*, decodeOpsPkg::*;
(
	input logic clock,
	input logic rstN,
	input logic istrValid,
	input istrWordT istrWord,
	input formModeT form,
	input immTypeT ity,
	input uCmdT uCmd,
	input uIxtT uCmdIx,
	input logic [btyWidth-1:0] bty,
	input regIdT laneReg [`REG_LANES],
	input logic [`REG_LANES-1:0] laneR0,
	input logic [`REG_LANES-1:0] laneR1,
	output logic idValid,
	output regIdT idRegN,
	output regIdT idRegM,
	output regIdT idRegO,
	output immT idImm,
	output uCmdT idUCmd,
	output uIxtT idUIxt
);

	regIdT nextRegN;
	regIdT nextRegM;
	regIdT nextRegO;
	immT nextImm;
	uIxtT nextUIxt;

	always_comb begin
		nextRegN = regZzr;
		nextRegM = regZzr;
		nextRegO = regZzr;
		nextImm = '0;
		nextUIxt = uCmdIx;

		case (form)
			formRegReg: begin
				nextRegN = laneReg[0];
				nextRegM = laneReg[1];
				nextRegO = laneReg[2];
				nextImm = {{(`IMM_WIDTH-5){1'b0}}, istrWord[4:0]};
			end

			formRegImmReg: begin
				nextRegN = laneReg[0];
				nextRegM = laneReg[1];
				nextRegO = regImm;
				nextImm = {{(`IMM_WIDTH-9){ity == ityNW}}, istrWord[24:16]};
			end

			formLdRegDispReg: begin
				nextRegN = laneReg[0];
				nextRegM = laneReg[1];
				nextRegO = regImm;
				nextImm = {{(`IMM_WIDTH-9){1'b0}}, istrWord[24:16]};
				nextUIxt = {bty[1:0], 1'b1, bty};
				// R0/R1 as base means PC/GBR relative
				if (laneR0[1] || laneR1[1]) begin
					nextRegM = laneR1[1] ? regGbr : regPc;
					nextUIxt = {bty[1:0], 1'b1, bty[2], 2'b00};
				end
			end

			formImm8Reg: begin
				nextRegN = laneReg[1];
				nextRegM = regImm;
				nextRegO = laneReg[1];
				case (ity)
					ityNW: nextImm = {{(`IMM_WIDTH-16){1'b1}}, istrWord[31:16]};
					itySW: nextImm = {{(`IMM_WIDTH-16){istrWord[31]}}, istrWord[31:16]};
					default: nextImm = {{(`IMM_WIDTH-16){1'b0}}, istrWord[31:16]};
				endcase
			end

			formImm12Z, formImm12N: begin
				nextRegN = regDlr;
				nextRegM = regDlr;
				nextRegO = regImm;
				nextImm = {{(`IMM_WIDTH-24){form == formImm12N}}, istrWord[7:0],
					istrWord[31:16]};
			end

			formInv: nextUIxt = '0;

			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			idValid <= 1'b0;
			idRegN <= regZzr;
			idRegM <= regZzr;
			idRegO <= regZzr;
			idImm <= '0;
			idUCmd <= cmdNop;
			idUIxt <= '0;
		end else begin
			idValid <= istrValid;
			// hold the last decode between strobes
			if (istrValid) begin
				idRegN <= nextRegN;
				idRegM <= nextRegM;
				idRegO <= nextRegO;
				idImm <= nextImm;
				idUCmd <= uCmd;
				idUIxt <= nextUIxt;
			end
		end
	end

endmodule

//--- src/instrDecoder.sv
// ####################
// Fx instruction decoder top level
// classifier, register lanes, router
// ####################

`timescale 1ns/1ps

`include "decoder_config.svh"

module instrDecoder
	import decodeTypesPkg::*, decodeOpsPkg::*;
(
	input logic clock,
	input logic rstN,
	input logic istrValid,
	input istrWordT istrWord,
	output logic idValid,
	output regIdT idRegN,
	output regIdT idRegM,
	output regIdT idRegO,
	output immT idImm,
	output uCmdT idUCmd,
	output uIxtT idUIxt
);

	formModeT form;
	immTypeT ity;
	uCmdT uCmd;
	uIxtT uCmdIx;
	logic [btyWidth-1:0] bty;
	regFieldT laneField [`REG_LANES];
	regIdT laneReg [`REG_LANES];
	logic [`REG_LANES-1:0] laneR0;
	logic [`REG_LANES-1:0] laneR1;

	opcodeClassifier opcodeClassifier_i (
		.istrWord(istrWord),
		.form(form),
		.ity(ity),
		.uCmd(uCmd),
		.uCmdIx(uCmdIx),
		.bty(bty),
		.laneField(laneField)
	);

	// lanes 0..2 feed N, M and O
	for (genvar lane = 0; lane < `REG_LANES; lane++) begin : genLane
		regFieldResolver regFieldResolver_i (
			.field(laneField[lane]),
			.regId(laneReg[lane]),
			.isR0(laneR0[lane]),
			.isR1(laneR1[lane])
		);
	end

	operandRouter operandRouter_i (
		.clock(clock),
		.rstN(rstN),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.form(form),
		.ity(ity),
		.uCmd(uCmd),
		.uCmdIx(uCmdIx),
		.bty(bty),
		.laneReg(laneReg),
		.laneR0(laneR0),
		.laneR1(laneR1),
		.idValid(idValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt)
	);

endmodule

//--- tests/clockGen.sv
// ####################
// testbench clock, 40 ns period
// reset held low for two cycles
// ####################

`timescale 1ns/1ps

module clockGen (
	output logic clock,
	output logic rstN
);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		rstN <= 1'b0;
		repeat (2) @(posedge clock);
		rstN <= 1'b1;
	end

endmodule

//--- tests/decoder_asserts.sv
// ####################
// concurrent assertions on the
// decoder top level, attached by bind
// ####################

`timescale 1ns/1ps

`include "decoder_config.svh"

module decoderAsserts
	import decodeOpsPkg::*;
(
	input logic clock,
	input logic rstN,
	input logic istrValid,
	input logic idValid,
	input logic [`REG_ID_WIDTH-1:0] idRegN,
	input logic [`REG_ID_WIDTH-1:0] idRegM,
	input logic [`REG_ID_WIDTH-1:0] idRegO,
	input logic [`IMM_WIDTH-1:0] idImm,
	input logic [`CMD_WIDTH-1:0] idUCmd,
	input logic [`CMD_WIDTH-1:0] idUIxt
);

	validFollowsStrobe: assert property (@(posedge clock)
		$past(rstN) |-> (idValid == $past(istrValid)))
		else $error("idValid does not follow istrValid by one cycle");

	// invalid words decode to the zero register everywhere
	invalidUsesZzr: assert property (@(posedge clock)
		(idUCmd == cmdInvOp) |-> (idRegN == regZzr && idRegM == regZzr && idRegO == regZzr))
		else $error("invalid command with a register other than ZZR");

	noUnknownOutputs: assert property (@(posedge clock)
		$past(rstN) |-> !$isunknown({idValid, idRegN, idRegM, idRegO, idImm, idUCmd, idUIxt}))
		else $error("unknown value on a decoder output after reset");

endmodule

//--- tests/decoderTb.sv
// ####################
// decoder testbench
// vectors from tests/decode_input.txt
// random gaps, one-cycle latency checks
// ####################

`timescale 1ns/1ps

`include "decoder_config.svh"

module decoderTb
	import decodeOpsPkg::*;
();

	localparam int maxVectors = 64;
	localparam int fieldsPerVector = 7;
	localparam logic [35:0] emptyEntry = 36'hFFFFFFFFF;

	logic clock;
	logic rstN;
	logic istrValid;
	logic [`ISTR_WIDTH-1:0] istrWord;
	logic idValid;
	logic [`REG_ID_WIDTH-1:0] idRegN;
	logic [`REG_ID_WIDTH-1:0] idRegM;
	logic [`REG_ID_WIDTH-1:0] idRegO;
	logic [`IMM_WIDTH-1:0] idImm;
	logic [`CMD_WIDTH-1:0] idUCmd;
	logic [`CMD_WIDTH-1:0] idUIxt;

	// word, N, M, O, immediate, command, index per vector
	logic [35:0] vecMem [0:maxVectors*fieldsPerVector-1];
	int numVectors;
	int timeoutLimit = 0;
	int cycleCount = 0;

	// what was driven one cycle earlier
	logic lastValid;
	int lastIdx;

	// expected outputs start at the reset values
	logic [35:0] expN;
	logic [35:0] expM;
	logic [35:0] expO;
	logic [35:0] expImm;
	logic [35:0] expCmd;
	logic [35:0] expIx;

	clockGen clockGen_i (
		.clock(clock),
		.rstN(rstN)
	);

	instrDecoder instrDecoder_i (
		.clock(clock),
		.rstN(rstN),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.idValid(idValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt)
	);

	bind instrDecoder decoderAsserts decoderAsserts_i (
		.clock(clock),
		.rstN(rstN),
		.istrValid(istrValid),
		.idValid(idValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt)
	);

	task automatic checkValue(input string name, input logic [35:0] actual,
			input logic [35:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s at %0t: got 0x%0h, expected 0x%0h", name, $time, actual,
				expected);
			$display("CHECKS FAILED");
			$fatal(1, "decoder output check failed");
		end
	endtask

	task automatic checkOutputs();
		int base;
		base = lastIdx * fieldsPerVector;
		if (lastValid) begin
			expN = vecMem[base + 1];
			expM = vecMem[base + 2];
			expO = vecMem[base + 3];
			expImm = vecMem[base + 4];
			expCmd = vecMem[base + 5];
			expIx = vecMem[base + 6];
		end
		checkValue("idValid", 36'(idValid), 36'(lastValid));
		checkValue("idRegN", 36'(idRegN), expN);
		checkValue("idRegM", 36'(idRegM), expM);
		checkValue("idRegO", 36'(idRegO), expO);
		checkValue("idImm", 36'(idImm), expImm);
		checkValue("idUCmd", 36'(idUCmd), expCmd);
		checkValue("idUIxt", 36'(idUIxt), expIx);
	endtask

	// drive on the rising edge and check the previous word at the falling edge
	task automatic runCycle(input logic drive, input int vecIdx);
		@(posedge clock);
		istrValid <= drive;
		if (drive)
			istrWord <= vecMem[vecIdx * fieldsPerVector][31:0];
		else
			istrWord <= $urandom;
		@(negedge clock);
		checkOutputs();
		lastValid = drive;
		lastIdx = vecIdx;
	endtask

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
			$display("timeout: run still going after %0d cycles", cycleCount);
			$display("CHECKS FAILED");
			$fatal(1, "decoder testbench timed out");
		end
	end

	initial begin
		int unsigned gap;
		istrValid <= 1'b0;
		istrWord <= '0;
		void'($urandom(97));
		lastValid = 1'b0;
		lastIdx = 0;
		expN = 36'(regZzr);
		expM = 36'(regZzr);
		expO = 36'(regZzr);
		expImm = '0;
		expCmd = 36'(cmdNop);
		expIx = '0;

		for (int i = 0; i < maxVectors * fieldsPerVector; i++)
			vecMem[i] = emptyEntry;
		$readmemh("tests/decode_input.txt", vecMem);
		numVectors = 0;
		while (numVectors < maxVectors && vecMem[numVectors * fieldsPerVector] != emptyEntry)
			numVectors++;
		if (numVectors == 0) begin
			$display("no vectors could be read from tests/decode_input.txt");
			$display("CHECKS FAILED");
			$fatal(1, "empty vector file");
		end
		timeoutLimit = numVectors * 6 + 20;

		wait (rstN === 1'b1);
		// idle cycles show the reset state
		runCycle(1'b0, 0);
		runCycle(1'b0, 0);

		for (int i = 0; i < numVectors; i++) begin
			gap = $urandom_range(3, 0);
			repeat (gap) runCycle(1'b0, 0);
			runCycle(1'b1, i);
		end
		runCycle(1'b0, 0);
		runCycle(1'b0, 0);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- tests/decode_input.txt
// columns: word, N, M, O, immediate, command, index (all hex)
// F0 alu group
1230F045 04 15 03 005 04 00
10F1F001 20 21 2F 001 04 01
1705F4F0 1F 10 10 010 04 05
1296F0AB 0A 1B 09 00B 04 06
1E77E0CE 1C 1E 07 00E 04 07
1232F045 3F 3F 3F 000 3F 00
2230F045 3F 3F 3F 000 3F 00
// F1 load/store with displacement
2012F134 03 04 3E 012 01 2A
0985F1A7 0A 07 3E 185 03 08
3040F521 02 21 3E 040 01 38
8010F1B0 0B 20 3E 010 02 08
9AFFF1C6 0C 16 3E 0FF 02 1D
B17FF1D0 0D 20 3E 17F 02 38
AA04F1E1 0E 11 3E 004 02 2E
4000F100 3F 3F 3F 000 3F 00
// F2 alu with 9-bit immediate
01A5F234 03 04 3E 1A5 04 00
1080F6F0 2F 20 3E 1FFFFFE80 04 00
5633F2EF 1E 1F 3E 033 04 05
71FFF212 21 02 3E 1FF 04 07
6000F256 05 06 3E 000 04 06
2000F200 3F 3F 3F 000 3F 00
// F8 16-bit immediates
BEEFF805 05 3E 05 0BEEF 05 08
1234F83A 1A 3E 1A 1FFFF1234 05 08
8001F940 20 3E 20 1FFFF8001 04 00
7FFFF95F 1F 3E 1F 07FFF 04 00
CAFEF861 21 3E 21 0CAFE 05 09
0000F880 3F 3F 3F 000 3F 00
// FA/FB 24-bit loads into DLR
3456FA12 22 22 3E 123456 05 08
0001FB80 22 22 3E 1FF800001 05 08
// non-Fx and unknown groups
1230D045 3F 3F 3F 000 3F 00
0000FC00 3F 3F 3F 000 3F 00
2012B134 3F 3F 3F 000 3F 00

//--- all.f
+incdir+include
src/decodeTypesPkg.sv
src/decodeOpsPkg.sv
src/opcodeClassifier.sv
src/regFieldResolver.sv
src/operandRouter.sv
src/instrDecoder.sv
tests/clockGen.sv
tests/decoder_asserts.sv
tests/decoderTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -j 0
TOP ?= decoderTb
FILELIST ?= all.f
OBJDIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the decoder testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
